// File: common/rf_if.sv
`timescale 1ns/1ns

interface rf_if
  import rv_pkg::*;
();

  // two combinational read ports
  reg_addr_t rs1;
  reg_addr_t rs2;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  // one write port, lands at the clock edge
  logic      we;
  reg_addr_t wa;
  xlen_t     wd;

  modport client (
    output rs1, rs2, we, wa, wd,
    input  rs1_data, rs2_data
  );

  modport server (
    input  rs1, rs2, we, wa, wd,
    output rs1_data, rs2_data
  );

endinterface

// File: common/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// register and instruction word width
`define RV_XLEN 32

// register index width
`define RV_REG_ADDR_W 5

// architectural registers, x0 included
`define RV_NUM_REGS 32

`endif

// File: common/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] xlen_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // alu operations, pass_b serves lui
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10
  } alu_op_e;

  // output of the decoder, carried by the decode stage register
  typedef struct packed {
    alu_op_e   alu_op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_imm;
    // sign-extended, or already shifted for lui
    xlen_t     imm;
    // low for rd == x0 and for illegal encodings
    logic      we;
    logic      illegal;
  } decoded_t;

  // one writeback beat
  typedef struct packed {
    reg_addr_t rd;
    xlen_t     data;
    logic      we;
    logic      illegal;
  } wb_t;

endpackage

// File: core/rv_alu.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_alu
  import rv_pkg::*;
(
  input  alu_op_e op,
  input  xlen_t   a,
  input  xlen_t   b,
  output xlen_t   y
);

  localparam int shamt_w = $clog2(`RV_XLEN);

  logic [shamt_w-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  // shifts only look at the low bits of b
  assign shamt       = b[shamt_w-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    y = a + b;
      alu_sub:    y = a - b;
      alu_sll:    y = a << shamt;
      alu_slt:    y = xlen_t'(lt_signed);
      alu_sltu:   y = xlen_t'(lt_unsigned);
      alu_xor:    y = a ^ b;
      alu_srl:    y = a >> shamt;
      alu_sra:    y = xlen_t'($signed(a) >>> shamt);
      alu_or:     y = a | b;
      alu_and:    y = a & b;
      // lui immediate arrives already shifted
      alu_pass_b: y = b;
      default:    y = '0;
    endcase
  end

endmodule

// File: core/rv_core.sv
`timescale 1ns/1ns

module rv_core
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      insn_valid,
  output logic      insn_ready,
  input  xlen_t     insn,
  output logic      wb_valid,
  input  logic      wb_ready,
  output reg_addr_t wb_rd,
  output xlen_t     wb_data,
  output logic      wb_illegal
);

  decoded_t dec_d;
  decoded_t dec_q;
  logic     dec_valid;
  logic     dec_ready;
  logic     res_valid;
  logic     res_ready;
  wb_t      res;
  wb_t      wb_q;

  rf_if rf_bus ();

  rv_decode u_decode (
    .insn (insn),
    .dec  (dec_d)
  );

  pipe_reg #(
    .T (decoded_t)
  ) u_dec_stage (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (insn_valid),
    .in_ready  (insn_ready),
    .in_data   (dec_d),
    .out_valid (dec_valid),
    .out_ready (dec_ready),
    .out_data  (dec_q)
  );

  rv_execute u_execute (
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec_q),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready),
    .wb        (wb_q),
    .rf        (rf_bus.client)
  );

  // writeback stage, also the forwarding source
  pipe_reg #(
    .T (wb_t)
  ) u_wb_stage (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (res_valid),
    .in_ready  (res_ready),
    .in_data   (res),
    .out_valid (wb_valid),
    .out_ready (wb_ready),
    .out_data  (wb_q)
  );

  rv_regfile u_regfile (
    .clk (clk),
    .rst (rst),
    .rf  (rf_bus.server)
  );

  assign wb_rd      = wb_q.rd;
  assign wb_data    = wb_q.data;
  assign wb_illegal = wb_q.illegal;

endmodule

// File: core/rv_decode.sv
`timescale 1ns/1ns

module rv_decode
  import rv_pkg::*;
(
  input  xlen_t    insn,
  output decoded_t dec
);

  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // shared funct3 map of op and op-imm, alt picks sub/sra
  function automatic alu_op_e funct3_op(logic [2:0] f3, logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  always_comb begin
    dec.alu_op  = alu_add;
    dec.rd      = insn[11:7];
    dec.rs1     = insn[19:15];
    dec.rs2     = insn[24:20];
    dec.use_imm = 1'b0;
    dec.imm     = {{20{insn[31]}}, insn[31:20]};
    dec.illegal = 1'b0;

    case (opcode)
      opcode_lui: begin
        dec.alu_op  = alu_pass_b;
        dec.use_imm = 1'b1;
        dec.imm     = {insn[31:12], 12'b0};
        dec.rs1     = '0;
        dec.rs2     = '0;
      end
      opcode_op_imm: begin
        dec.use_imm = 1'b1;
        dec.rs2     = '0;
        dec.alu_op  = funct3_op(funct3, 1'b0);
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          // shift-immediate, shamt in the rs2 field
          dec.imm    = {27'b0, insn[24:20]};
          dec.alu_op = funct3_op(funct3, funct7 == funct7_alt);
          if (funct7 != funct7_base && !(funct3 == 3'b101 && funct7 == funct7_alt)) begin
            dec.illegal = 1'b1;
          end
        end
      end
      opcode_op: begin
        dec.alu_op = funct3_op(funct3, funct7 == funct7_alt);
        if (funct7 == funct7_alt) begin
          // only sub and sra have the alternate encoding
          dec.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
        end else if (funct7 != funct7_base) begin
          dec.illegal = 1'b1;
        end
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase

    // x0 never written, so later stages skip the check
    dec.we = !dec.illegal && (dec.rd != '0);
  end

endmodule

// File: core/rv_execute.sv
`timescale 1ns/1ns

module rv_execute
  import rv_pkg::*;
(
  input  logic     dec_valid,
  output logic     dec_ready,
  input  decoded_t dec,
  output logic     res_valid,
  input  logic     res_ready,
  output wb_t      res,
  input  logic     wb_valid,
  input  logic     wb_ready,
  input  wb_t      wb,
  rf_if.client     rf
);

  logic  fwd_rs1;
  logic  fwd_rs2;
  xlen_t rs1_val;
  xlen_t rs2_val;
  xlen_t op_b;
  xlen_t alu_y;

  // no state here, so the stream passes straight through
  assign res_valid = dec_valid;
  assign dec_ready = res_ready;

  assign rf.rs1 = dec.rs1;
  assign rf.rs2 = dec.rs2;

  // the writeback entry has not reached the register file yet
  assign fwd_rs1 = wb_valid && wb.we && (wb.rd == dec.rs1);
  assign fwd_rs2 = wb_valid && wb.we && (wb.rd == dec.rs2);

  assign rs1_val = fwd_rs1 ? wb.data : rf.rs1_data;
  assign rs2_val = fwd_rs2 ? wb.data : rf.rs2_data;
  assign op_b    = dec.use_imm ? dec.imm : rs2_val;

  rv_alu u_alu (
    .op (dec.alu_op),
    .a  (rs1_val),
    .b  (op_b),
    .y  (alu_y)
  );

  always_comb begin
    res.rd      = dec.rd;
    res.data    = dec.illegal ? '0 : alu_y;
    res.we      = dec.we;
    res.illegal = dec.illegal;
  end

  // commit only when the writeback beat is taken
  assign rf.we = wb_valid && wb_ready && wb.we;
  assign rf.wa = wb.rd;
  assign rf.wd = wb.data;

endmodule

// File: core/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_regfile
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  rf_if.server     rf
);

  // x0 has no storage
  xlen_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we && rf.wa != '0) begin
      regs[rf.wa] <= rf.wd;
    end
  end

  // combinational reads
  always_comb begin
    if (rf.rs1 == '0) begin
      rf.rs1_data = '0;
    end else begin
      rf.rs1_data = regs[rf.rs1];
    end
    if (rf.rs2 == '0) begin
      rf.rs2_data = '0;
    end else begin
      rf.rs2_data = regs[rf.rs2];
    end
  end

endmodule

// File: hw/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg
  import rv_pkg::*;
#(
  parameter type T = xlen_t
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  logic full;
  T     data_q;

  // accept when empty or when the held beat leaves this cycle
  assign in_ready  = !full || out_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
    end else if (out_valid && out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# compile with Verilator and run, exit status reports pass or fail
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f sim.f --top-module rv_core_tb -o rv_core_sim &&
  ./obj_dir/rv_core_sim ||
  exit 1

// File: sim.f
+incdir+common
common/rv_pkg.sv
common/rf_if.sv
hw/pipe_reg.sv
core/rv_decode.sv
core/rv_regfile.sv
core/rv_alu.sv
core/rv_execute.sv
core/rv_core.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

// File: test/rv_core_assert.sv
`timescale 1ns/1ns

module rv_core_assert
  import rv_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      insn_valid,
  input logic      insn_ready,
  input xlen_t     insn,
  input logic      wb_valid,
  input logic      wb_ready,
  input reg_addr_t wb_rd,
  input xlen_t     wb_data,
  input logic      wb_illegal
);

  // a stalled beat keeps valid and payload until it is taken
  insn_hold: assert property (@(posedge clk) disable iff (rst)
    insn_valid && !insn_ready |=> insn_valid && $stable(insn))
    else $error("instruction stream changed while stalled");

  wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_valid && !wb_ready |=> wb_valid && $stable({wb_rd, wb_data, wb_illegal}))
    else $error("writeback stream changed while stalled");

  // an accepted writeback frees every stage behind it
  ready_chain: assert property (@(posedge clk) disable iff (rst)
    wb_ready |-> insn_ready)
    else $error("insn_ready low although wb_ready is high");

  // pipeline comes out of reset empty
  empty_after_reset: assert property (@(posedge clk) $fell(rst) |-> !wb_valid)
    else $error("wb_valid high in the first cycle after reset");

endmodule

bind rv_core rv_core_assert u_assert (.*);

// File: test/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb
  import rv_pkg::*;
();

  localparam logic [6:0] op_imm  = 7'b0010011;
  localparam logic [6:0] op_reg  = 7'b0110011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam int num_passes = 2;

  logic      clk;
  logic      rst;
  logic      insn_valid;
  logic      insn_ready;
  xlen_t     insn;
  logic      wb_valid;
  logic      wb_ready;
  reg_addr_t wb_rd;
  xlen_t     wb_data;
  logic      wb_illegal;

  // one entry per table row
  string     row_name[$];
  xlen_t     row_insn[$];
  reg_addr_t row_rd[$];
  xlen_t     row_data[$];
  logic      row_ill[$];

  logic stall_mode;
  int   cycle_count = 0;
  int   cycle_limit = 1000;

  rv_core u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, writeback stream stopped", cycle_count);
      $display("TESTS FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  // random back-pressure in the second pass
  initial begin
    wb_ready = 1'b1;
    void'($urandom(32'h3726e03a));
    forever begin
      @(negedge clk);
      if (stall_mode) begin
        wb_ready <= ($urandom % 3) != 0;
      end else begin
        wb_ready <= 1'b1;
      end
    end
  end

  function automatic xlen_t i_word(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic xlen_t r_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic xlen_t u_word(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_row(string name, xlen_t word, reg_addr_t rd, xlen_t data, logic ill);
    row_name.push_back(name);
    row_insn.push_back(word);
    row_rd.push_back(rd);
    row_data.push_back(data);
    row_ill.push_back(ill);
  endtask

  // expected values worked out by hand, each row builds on the ones above
  task automatic build_table();
    add_row("add_zero", r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd5), 5'd5, 32'h00000000, 1'b0);
    add_row("lui", u_word(20'h12345, 5'd1), 5'd1, 32'h12345000, 1'b0);
    add_row("addi_neg", i_word(12'hffb, 5'd0, 3'd0, 5'd2, op_imm), 5'd2, 32'hfffffffb, 1'b0);
    add_row("slti", i_word(12'hffc, 5'd2, 3'd2, 5'd3, op_imm), 5'd3, 32'h00000001, 1'b0);
    add_row("sltiu", i_word(12'h005, 5'd2, 3'd3, 5'd4, op_imm), 5'd4, 32'h00000000, 1'b0);
    add_row("xori", i_word(12'h0ff, 5'd1, 3'd4, 5'd5, op_imm), 5'd5, 32'h123450ff, 1'b0);
    add_row("ori", i_word(12'h7ff, 5'd1, 3'd6, 5'd6, op_imm), 5'd6, 32'h123457ff, 1'b0);
    add_row("andi", i_word(12'hff0, 5'd6, 3'd7, 5'd7, op_imm), 5'd7, 32'h123457f0, 1'b0);
    add_row("slli", i_word(12'h01f, 5'd3, 3'd1, 5'd8, op_imm), 5'd8, 32'h80000000, 1'b0);
    add_row("srli", i_word(12'h004, 5'd8, 3'd5, 5'd9, op_imm), 5'd9, 32'h08000000, 1'b0);
    add_row("srai", i_word(12'h404, 5'd8, 3'd5, 5'd10, op_imm), 5'd10, 32'hf8000000, 1'b0);
    // each of these reads the result of the row just before it
    add_row("add_fwd", r_word(7'h00, 5'd1, 5'd10, 3'd0, 5'd11), 5'd11, 32'h0a345000, 1'b0);
    add_row("sub_fwd", r_word(7'h20, 5'd2, 5'd11, 3'd0, 5'd12), 5'd12, 32'h0a345005, 1'b0);
    add_row("sll_fwd", r_word(7'h00, 5'd3, 5'd12, 3'd1, 5'd13), 5'd13, 32'h1468a00a, 1'b0);
    add_row("slt_fwd", r_word(7'h00, 5'd13, 5'd2, 3'd2, 5'd14), 5'd14, 32'h00000001, 1'b0);
    add_row("sltu_fwd", r_word(7'h00, 5'd2, 5'd14, 3'd3, 5'd15), 5'd15, 32'h00000001, 1'b0);
    add_row("xor_fwd", r_word(7'h00, 5'd13, 5'd15, 3'd4, 5'd16), 5'd16, 32'h1468a00b, 1'b0);
    add_row("srl_fwd", r_word(7'h00, 5'd15, 5'd16, 3'd5, 5'd17), 5'd17, 32'h0a345005, 1'b0);
    add_row("sra_fwd", r_word(7'h20, 5'd17, 5'd2, 3'd5, 5'd18), 5'd18, 32'hffffffff, 1'b0);
    add_row("and_fwd", r_word(7'h00, 5'd12, 5'd18, 3'd7, 5'd19), 5'd19, 32'h0a345005, 1'b0);
    add_row("or_fwd", r_word(7'h00, 5'd8, 5'd19, 3'd6, 5'd20), 5'd20, 32'h8a345005, 1'b0);
    add_row("add_both", r_word(7'h00, 5'd20, 5'd20, 3'd0, 5'd21), 5'd21, 32'h1468a00a, 1'b0);
    add_row("addi_x0", i_word(12'h007, 5'd1, 3'd0, 5'd0, op_imm), 5'd0, 32'h12345007, 1'b0);
    add_row("read_x0", r_word(7'h00, 5'd3, 5'd0, 3'd0, 5'd22), 5'd22, 32'h00000001, 1'b0);
    add_row("load", i_word(12'h000, 5'd1, 3'd2, 5'd3, op_load), 5'd3, 32'h00000000, 1'b1);
    add_row("after_load", r_word(7'h00, 5'd0, 5'd3, 3'd0, 5'd23), 5'd23, 32'h00000001, 1'b0);
    add_row("bad_funct7", r_word(7'h20, 5'd2, 5'd1, 3'd6, 5'd4), 5'd4, 32'h00000000, 1'b1);
  endtask

  task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
    if (exp !== act) begin
      $display("mismatch %s rd: expected %0d, actual %0d", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "wrong writeback register");
    end
  endtask

  task automatic check_data(string name, xlen_t exp, xlen_t act);
    if (exp !== act) begin
      $display("mismatch %s data: expected %h, actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "wrong writeback data");
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("mismatch %s illegal: expected %b, actual %b", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "wrong illegal flag");
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
  endtask

  // valid stays high from row to row so dependent rows issue back to back
  task automatic drive_rows();
    for (int i = 0; i < row_insn.size(); i++) begin
      @(negedge clk);
      insn_valid = 1'b1;
      insn = row_insn[i];
      @(posedge clk);
      while (!insn_ready) @(posedge clk);
    end
    @(negedge clk);
    insn_valid = 1'b0;
    insn = '0;
  endtask

  task automatic collect_rows();
    int idx;
    idx = 0;
    while (idx < row_insn.size()) begin
      @(posedge clk);
      if (wb_valid && wb_ready) begin
        check_addr(row_name[idx], row_rd[idx], wb_rd);
        check_data(row_name[idx], row_data[idx], wb_data);
        check_flag(row_name[idx], row_ill[idx], wb_illegal);
        idx++;
      end
    end
  endtask

  task automatic check_idle();
    repeat (4) @(negedge clk);
    if (wb_valid) begin
      $display("extra writeback beat after the last row");
      $display("TESTS FAILED");
      $fatal(1, "extra writeback beat");
    end
  endtask

  initial begin
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    stall_mode = 1'b0;
    build_table();
    cycle_limit = num_passes * 20 * row_insn.size() + 50;
    for (int pass_idx = 0; pass_idx < num_passes; pass_idx++) begin
      stall_mode = (pass_idx == 1);
      apply_reset();
      fork
        drive_rows();
        collect_rows();
      join
      check_idle();
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule
